// File: rtl/ddr_pkg.sv
`default_nettype none

package ddr_pkg;

	// field widths with a meaning of their own
	typedef logic [11:0] regf_addr_t;   // register file address
	typedef logic [4:0]  dev_index_t;   // device table index
	typedef logic [6:0]  target_addr_t; // dynamic address on the bus
	typedef logic [4:0]  stall_cnt_t;   // scl stall length in scl cycles
	typedef logic [7:0]  byte_t;        // special data byte to the serializer

	// one state per field of the ddr frame
	typedef enum logic [4:0] {
		IDLE,
		CMD_PRE,      // command preamble
		RW_BIT,
		SEVEN_ZEROS,
		ADDRESS,
		PARITY,       // command or data parity, told apart by the data phase flag
		ACK_PRE,      // write only, controller hands sda to target
		ACK_WAIT,
		DATA_BYTE1,
		DATA_BYTE2,
		PAD_ZEROS,    // zero byte after an odd last byte
		DATA_PRE,
		ABORT_BIT,
		CRC_PRE1,
		CRC_PRE2,
		CRC_TOKEN,
		CRC_VALUE,
		ERROR,
		RESTART,
		EXIT
	} frame_state_e;

	// serializer modes, encodings fixed by the phy
	typedef enum logic [3:0] {
		SPECIAL_PRE     = 4'd0,
		SER_ADDRESS     = 4'd1,
		ONE_PRE         = 4'd2,
		SEVEN_ZEROS_TX  = 4'd3,
		CALC_PARITY     = 4'd4,
		ZERO_PRE        = 4'd6,
		SER_BYTE        = 4'd7,
		TOKEN_CRC       = 4'd12,
		CRC_VALUE_TX    = 4'd13,
		EXIT_PATTERN    = 4'd14,
		RESTART_PATTERN = 4'd15
	} tx_mode_e;

	// deserializer modes
	typedef enum logic [2:0] {
		PREAMBLE     = 3'd0,
		CHECK_CRC    = 3'd2,
		DESER_BYTE   = 3'd3,
		RX_ERROR     = 3'd4,
		CHECK_PARITY = 3'd6,
		CHECK_TOKEN  = 3'd7
	} rx_mode_e;

	// codes reported to the register file, gaps are codes this engine never raises
	typedef enum logic [3:0] {
		SUCCESS        = 4'd0,
		CRC_ERR        = 4'd1,
		PARITY_ERR     = 4'd2,
		FRAME_ERR      = 4'd3,
		NACK_ERR       = 4'd5,
		SHORT_READ_ERR = 4'd7,
		BUS_ABORT_ERR  = 4'd9
	} err_code_e;

	localparam regf_addr_t   WR_BASE_ADDR       = 12'd1;   // first byte sent on a write
	localparam regf_addr_t   RD_BASE_ADDR       = 12'd10;  // first byte stored on a read
	localparam regf_addr_t   PAD_ADDR           = 12'd999; // location holding the zero pad byte
	localparam target_addr_t TARGET_ADDR_OFFSET = 7'd8;
	localparam stall_cnt_t   RESTART_STALL      = 5'd10;
	localparam stall_cnt_t   EXIT_STALL         = 5'd16;

endpackage

`default_nettype wire

// File: rtl/ddr_frame_fsm.sv
`default_nettype none

module ddr_frame_fsm
(
	input  wire                   i_sys_clk,
	input  wire                   i_sys_rst,
	input  wire                   i_engine_en,
	input  wire                   i_tx_mode_done,
	input  wire                   i_rx_mode_done,
	input  wire                   i_rx_pre,
	input  wire                   i_rx_error,
	input  wire                   i_frmcnt_last,
	input  wire                   i_regf_toc,        // 0 restart, 1 exit
	input  wire                   i_regf_short_read,
	input  wire                   i_regf_wr_rd_bit,  // 0 write, 1 read
	output ddr_pkg::frame_state_e o_state,
	output logic                  o_data_phase,
	output ddr_pkg::err_code_e    o_regf_error_type,
	output logic                  o_regf_abort
);

	import ddr_pkg::*;

	frame_state_e next_state;
	frame_state_e end_state;  // tail pattern once the frame is over
	logic         field_done; // current field finished on either side
	logic         err_hit;
	err_code_e    err_code;
	logic         abort_hit;

	assign field_done = i_tx_mode_done | i_rx_mode_done;
	assign end_state  = i_regf_toc ? EXIT : RESTART;

	always_comb
	begin
		next_state = o_state;  // hold until the phy reports the field done
		err_hit    = 1'b0;
		err_code   = SUCCESS;
		abort_hit  = 1'b0;
		case (o_state)
			IDLE:
				if (i_engine_en)
					next_state = CMD_PRE;
			CMD_PRE:
				if (i_tx_mode_done)
					next_state = RW_BIT;
			RW_BIT:
				if (i_tx_mode_done)
					next_state = SEVEN_ZEROS;
			SEVEN_ZEROS:
				if (i_tx_mode_done)
					next_state = ADDRESS;
			ADDRESS:
				if (i_tx_mode_done)
					next_state = PARITY;
			PARITY:
			begin
				if (field_done)
				begin
					if (!o_data_phase)  // command parity
						next_state = i_regf_wr_rd_bit ? DATA_PRE : ACK_PRE;
					else if (!i_regf_wr_rd_bit)
						next_state = i_frmcnt_last ? CRC_PRE1 : DATA_PRE;
					else if (i_rx_error)  // bad parity on read data
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = PARITY_ERR;
					end
					else
						next_state = DATA_PRE;
				end
			end
			ACK_PRE:
				if (i_tx_mode_done)
					next_state = ACK_WAIT;
			ACK_WAIT:
			begin
				if (i_rx_mode_done)
				begin
					if (!i_rx_pre)
						next_state = DATA_BYTE1;  // ack is a low preamble
					else
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = NACK_ERR;
					end
				end
			end
			// a high last flag in the first byte means the word carries only this byte
			DATA_BYTE1:
				if (field_done)
					next_state = i_frmcnt_last ? PAD_ZEROS : DATA_BYTE2;
			DATA_BYTE2, PAD_ZEROS:
				if (field_done)
					next_state = PARITY;
			DATA_PRE:
			begin
				if (field_done)
				begin
					if (!i_regf_wr_rd_bit || i_rx_pre)
						next_state = ABORT_BIT;  // another word offered
					else if (!i_frmcnt_last && i_regf_short_read)
					begin
						next_state = ERROR;  // target stopped before the last word
						err_hit    = 1'b1;
						err_code   = SHORT_READ_ERR;
					end
					else
						next_state = CRC_PRE2;  // target moves on to the crc word
				end
			end
			ABORT_BIT:
			begin
				if (field_done)
				begin
					// target pulls the bit low on a write, controller stops a read at the end
					if ((!i_regf_wr_rd_bit && !i_rx_pre) || (i_regf_wr_rd_bit && i_frmcnt_last))
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = BUS_ABORT_ERR;
						abort_hit  = 1'b1;
					end
					else
						next_state = DATA_BYTE1;
				end
			end
			CRC_PRE1:
				if (field_done)
					next_state = CRC_PRE2;
			CRC_PRE2:
			begin
				if (field_done)
				begin
					if (i_regf_wr_rd_bit && !i_rx_pre)
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = FRAME_ERR;
					end
					else
						next_state = CRC_TOKEN;
				end
			end
			CRC_TOKEN:
			begin
				if (field_done)
				begin
					if (i_regf_wr_rd_bit && i_rx_error)  // wrong token from target
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = FRAME_ERR;
					end
					else
						next_state = CRC_VALUE;
				end
			end
			CRC_VALUE:
			begin
				if (field_done)
				begin
					if (i_regf_wr_rd_bit && i_rx_error)
					begin
						next_state = ERROR;
						err_hit    = 1'b1;
						err_code   = CRC_ERR;
					end
					else
						next_state = end_state;
				end
			end
			ERROR:
				if (i_rx_mode_done)  // phy has released the bus
					next_state = end_state;
			RESTART, EXIT:
				if (i_tx_mode_done)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_state           <= IDLE;
			o_data_phase      <= 1'b0;
			o_regf_error_type <= SUCCESS;
			o_regf_abort      <= 1'b0;
		end
		else
		begin
			o_state      <= next_state;
			o_regf_abort <= abort_hit;  // single cycle, taken with the state change
			if (o_state == IDLE && i_engine_en)
				o_regf_error_type <= SUCCESS;  // fresh transfer
			else if (err_hit)
				o_regf_error_type <= err_code;
			if (o_state == IDLE)
				o_data_phase <= 1'b0;
			else if (o_state == DATA_BYTE2 || o_state == PAD_ZEROS)
				o_data_phase <= 1'b1;  // later parities cover data
		end
	end

endmodule

`default_nettype wire

// File: rtl/ddr_phy_ctrl.sv
`default_nettype none

module ddr_phy_ctrl
(
	input  wire ddr_pkg::frame_state_e i_state,
	input  wire                        i_data_phase,
	input  wire                        i_regf_wr_rd_bit,  // 0 write, 1 read
	input  wire                        i_frmcnt_last,
	input  wire                        i_regf_toc,
	input  wire ddr_pkg::dev_index_t   i_regf_dev_index,
	input  wire                        i_tx_mode_done,
	output logic                       o_tx_en,
	output ddr_pkg::tx_mode_e          o_tx_mode,
	output logic                       o_rx_en,
	output ddr_pkg::rx_mode_e          o_rx_mode,
	output logic                       o_regf_rd_en,
	output logic                       o_regf_wr_en,
	output ddr_pkg::byte_t             o_tx_special_data,
	output logic                       o_sclstall_en,
	output ddr_pkg::stall_cnt_t        o_sclstall_no_of_cycles,
	output logic                       o_engine_done
);

	import ddr_pkg::*;

	logic rd; // read transfer

	assign rd = i_regf_wr_rd_bit;

	always_comb
	begin
		o_tx_en                 = 1'b0;
		o_tx_mode               = SPECIAL_PRE;
		o_rx_en                 = 1'b0;
		o_rx_mode               = PREAMBLE;
		o_regf_rd_en            = 1'b0;
		o_regf_wr_en            = 1'b0;
		o_tx_special_data       = '0;
		o_sclstall_en           = 1'b0;
		o_sclstall_no_of_cycles = '0;
		o_engine_done           = 1'b0;
		case (i_state)
			CMD_PRE:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = SPECIAL_PRE;
			end
			RW_BIT:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = rd ? ONE_PRE : ZERO_PRE;  // the bit itself
			end
			SEVEN_ZEROS:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = SEVEN_ZEROS_TX;
			end
			ADDRESS:
			begin
				o_tx_en           = 1'b1;
				o_tx_mode         = SER_ADDRESS;
				o_tx_special_data = byte_t'(target_addr_t'(i_regf_dev_index) + TARGET_ADDR_OFFSET);
			end
			PARITY:
			begin
				if (rd && i_data_phase)  // target sends parity of read data
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = CHECK_PARITY;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = CALC_PARITY;
				end
			end
			ACK_PRE:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = ONE_PRE;
			end
			ACK_WAIT:
			begin
				o_rx_en   = 1'b1;
				o_rx_mode = PREAMBLE;
			end
			DATA_BYTE1, DATA_BYTE2, PAD_ZEROS:
			begin
				if (rd)
				begin
					o_rx_en      = 1'b1;
					o_rx_mode    = DESER_BYTE;
					o_regf_wr_en = (i_state != PAD_ZEROS);  // pad byte is not stored
				end
				else
				begin
					o_tx_en      = 1'b1;
					o_tx_mode    = SER_BYTE;
					o_regf_rd_en = 1'b1;
				end
			end
			DATA_PRE, CRC_PRE2:
			begin
				if (rd)
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = PREAMBLE;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = ONE_PRE;
				end
			end
			ABORT_BIT:
			begin
				if (rd)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = i_frmcnt_last ? ZERO_PRE : ONE_PRE;  // low bit stops the target
				end
				else
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = PREAMBLE;
				end
			end
			CRC_PRE1:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = ZERO_PRE;
			end
			CRC_TOKEN:
			begin
				o_tx_en   = !rd;
				o_tx_mode = TOKEN_CRC;
				o_rx_en   = rd;
				o_rx_mode = CHECK_TOKEN;
			end
			CRC_VALUE:
			begin
				o_tx_en   = !rd;
				o_tx_mode = CRC_VALUE_TX;
				o_rx_en   = rd;
				o_rx_mode = CHECK_CRC;
			end
			ERROR:
			begin
				o_rx_en   = 1'b1;
				o_rx_mode = RX_ERROR;
			end
			RESTART, EXIT:
			begin
				o_tx_en                 = 1'b1;
				o_tx_mode               = (i_state == EXIT) ? EXIT_PATTERN : RESTART_PATTERN;
				o_sclstall_en           = !i_tx_mode_done;  // released with the pattern
				o_sclstall_no_of_cycles = i_regf_toc ? EXIT_STALL : RESTART_STALL;
				o_engine_done           = (i_state == EXIT) && i_tx_mode_done;
			end
			default:
				o_tx_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/ddr_regf_addr_gen.sv
`default_nettype none

module ddr_regf_addr_gen
(
	input  wire                        i_sys_clk,
	input  wire                        i_sys_rst,
	input  wire ddr_pkg::frame_state_e i_state,
	input  wire                        i_regf_wr_rd_bit,  // 0 write, 1 read
	input  wire                        i_tx_mode_done,
	input  wire                        i_rx_mode_done,
	output ddr_pkg::regf_addr_t        o_regf_addr
);

	import ddr_pkg::*;

	logic field_done;

	assign field_done = i_tx_mode_done | i_rx_mode_done;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_regf_addr <= '0;
		else
		begin
			case (i_state)
				ACK_PRE:
					if (i_tx_mode_done && !i_regf_wr_rd_bit)
						o_regf_addr <= WR_BASE_ADDR;  // ready as ack_wait starts
				// command parity is always sent, data parity on a read is checked
				PARITY:
					if (i_tx_mode_done && i_regf_wr_rd_bit)
						o_regf_addr <= RD_BASE_ADDR;
				DATA_BYTE1, DATA_BYTE2:
					if (field_done)
						o_regf_addr <= o_regf_addr + regf_addr_t'(1);  // next byte
				PAD_ZEROS:
					if (!i_regf_wr_rd_bit)
						o_regf_addr <= PAD_ADDR;  // zero byte for the odd tail
				default:
					o_regf_addr <= o_regf_addr;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/ddr_engine.sv
`default_nettype none

module ddr_engine
(
	input  wire                      i_sys_clk,
	input  wire                      i_sys_rst,
	input  wire                      i_engine_en,
	input  wire                      i_regf_toc,        // 0 restart, 1 exit
	input  wire ddr_pkg::dev_index_t i_regf_dev_index,
	input  wire                      i_regf_short_read,
	input  wire                      i_regf_wr_rd_bit,  // 0 write, 1 read
	input  wire                      i_tx_mode_done,
	input  wire                      i_rx_mode_done,
	input  wire                      i_rx_pre,
	input  wire                      i_rx_error,
	input  wire                      i_frmcnt_last,
	output wire                      o_tx_en,
	output ddr_pkg::tx_mode_e        o_tx_mode,
	output wire                      o_rx_en,
	output ddr_pkg::rx_mode_e        o_rx_mode,
	output wire                      o_regf_rd_en,
	output wire                      o_regf_wr_en,
	output ddr_pkg::regf_addr_t      o_regf_addr,
	output ddr_pkg::byte_t           o_tx_special_data,
	output wire                      o_sclstall_en,
	output ddr_pkg::stall_cnt_t      o_sclstall_no_of_cycles,
	output wire                      o_engine_done,
	output ddr_pkg::err_code_e       o_regf_error_type,
	output wire                      o_regf_abort
);

	import ddr_pkg::*;

	frame_state_e state;      // current frame field
	logic         data_phase; // command over, parity now covers data

	ddr_frame_fsm u_frame_fsm (
		.i_sys_clk         (i_sys_clk),
		.i_sys_rst         (i_sys_rst),
		.i_engine_en       (i_engine_en),
		.i_tx_mode_done    (i_tx_mode_done),
		.i_rx_mode_done    (i_rx_mode_done),
		.i_rx_pre          (i_rx_pre),
		.i_rx_error        (i_rx_error),
		.i_frmcnt_last     (i_frmcnt_last),
		.i_regf_toc        (i_regf_toc),
		.i_regf_short_read (i_regf_short_read),
		.i_regf_wr_rd_bit  (i_regf_wr_rd_bit),
		.o_state           (state),
		.o_data_phase      (data_phase),
		.o_regf_error_type (o_regf_error_type),
		.o_regf_abort      (o_regf_abort)
	);

	ddr_phy_ctrl u_phy_ctrl (
		.i_state                 (state),
		.i_data_phase            (data_phase),
		.i_regf_wr_rd_bit        (i_regf_wr_rd_bit),
		.i_frmcnt_last           (i_frmcnt_last),
		.i_regf_toc              (i_regf_toc),
		.i_regf_dev_index        (i_regf_dev_index),
		.i_tx_mode_done          (i_tx_mode_done),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_regf_rd_en            (o_regf_rd_en),
		.o_regf_wr_en            (o_regf_wr_en),
		.o_tx_special_data       (o_tx_special_data),
		.o_sclstall_en           (o_sclstall_en),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
		.o_engine_done           (o_engine_done)
	);

	// address only follows the state, the done pulses and the direction
	ddr_regf_addr_gen u_regf_addr_gen (
		.i_sys_clk        (i_sys_clk),
		.i_sys_rst        (i_sys_rst),
		.i_state          (state),
		.i_regf_wr_rd_bit (i_regf_wr_rd_bit),
		.i_tx_mode_done   (i_tx_mode_done),
		.i_rx_mode_done   (i_rx_mode_done),
		.o_regf_addr      (o_regf_addr)
	);

endmodule

`default_nettype wire

// File: dv/ddr_engine_props.sv
`default_nettype none

module ddr_engine_props
(
	input wire                        i_sys_clk,
	input wire                        i_sys_rst,
	input wire ddr_pkg::frame_state_e i_state,
	input wire                        i_tx_en,
	input wire                        i_rx_en,
	input wire ddr_pkg::tx_mode_e     i_tx_mode,
	input wire                        i_tx_mode_done,
	input wire                        i_regf_rd_en,
	input wire                        i_regf_wr_en,
	input wire ddr_pkg::regf_addr_t   i_regf_addr,
	input wire                        i_sclstall_en,
	input wire                        i_engine_done,
	input wire ddr_pkg::err_code_e    i_regf_error_type,
	input wire                        i_regf_abort
);

	import ddr_pkg::*;

	int fail_cnt = 0; // read by the testbench at the end of the run

	// every output at its idle value while reset is held
	assert property (@(posedge i_sys_clk) !i_sys_rst |-> !i_tx_en && !i_rx_en && !i_regf_rd_en
		&& !i_regf_wr_en && !i_sclstall_en && !i_engine_done && !i_regf_abort
		&& i_state == IDLE && i_regf_error_type == SUCCESS && i_regf_addr == '0)
	else
	begin
		$error("outputs not at reset values during reset");
		fail_cnt++;
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst) !(i_tx_en && i_rx_en))
	else
	begin
		$error("tx and rx enabled together");
		fail_cnt++;
	end

	// stall only around the tail pattern
	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_sclstall_en |-> i_tx_mode inside {RESTART_PATTERN, EXIT_PATTERN})
	else
	begin
		$error("scl stall outside restart or exit pattern");
		fail_cnt++;
	end

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_engine_done |-> i_tx_mode == EXIT_PATTERN && i_tx_mode_done)
	else
	begin
		$error("engine done outside the end of the exit pattern");
		fail_cnt++;
	end

endmodule

bind ddr_engine ddr_engine_props props_i (
	.i_sys_clk         (i_sys_clk),
	.i_sys_rst         (i_sys_rst),
	.i_state           (state),
	.i_tx_en           (o_tx_en),
	.i_rx_en           (o_rx_en),
	.i_tx_mode         (o_tx_mode),
	.i_tx_mode_done    (i_tx_mode_done),
	.i_regf_rd_en      (o_regf_rd_en),
	.i_regf_wr_en      (o_regf_wr_en),
	.i_regf_addr       (o_regf_addr),
	.i_sclstall_en     (o_sclstall_en),
	.i_engine_done     (o_engine_done),
	.i_regf_error_type (o_regf_error_type),
	.i_regf_abort      (o_regf_abort)
);

`default_nettype wire

// File: dv/ddr_engine_tb.sv
`default_nettype none

module ddr_engine_tb;

	import ddr_pkg::*;

	localparam int WAIT_LIMIT = 40; // cycles allowed for the engine to raise an enable

	logic       i_sys_clk;
	logic       i_sys_rst;
	logic       i_engine_en;
	logic       i_regf_toc;
	dev_index_t i_regf_dev_index;
	logic       i_regf_short_read;
	logic       i_regf_wr_rd_bit;
	logic       i_tx_mode_done;
	logic       i_rx_mode_done;
	logic       i_rx_pre;
	logic       i_rx_error;
	logic       i_frmcnt_last;
	logic       o_tx_en;
	tx_mode_e   o_tx_mode;
	logic       o_rx_en;
	rx_mode_e   o_rx_mode;
	logic       o_regf_rd_en;
	logic       o_regf_wr_en;
	regf_addr_t o_regf_addr;
	byte_t      o_tx_special_data;
	logic       o_sclstall_en;
	stall_cnt_t o_sclstall_no_of_cycles;
	logic       o_engine_done;
	err_code_e  o_regf_error_type;
	logic       o_regf_abort;

	logic [7:0] lfsr;        // galois lfsr, one step per bit taken
	tx_mode_e   mode_q[$];   // expected tx modes of the leading fields
	tx_mode_e   exp_mode;
	logic       mode_chk;
	logic       byte_done;   // done pulse of a data byte field
	int         byte_idx;
	regf_addr_t exp_base;
	byte_t      exp_special;
	stall_cnt_t exp_stall;
	tx_mode_e   exp_pattern;
	err_code_e  exp_err;
	int         exp_done;
	int         exp_abort;
	logic       frame_end;   // one cycle after the last field of a frame
	int         done_cnt = 0;
	int         abort_cnt = 0;
	int         done_mark;
	int         abort_mark;

	ddr_engine ddr_engine_i (.*);

	initial
	begin
		i_sys_clk = 1'b0;
		forever
			#4 i_sys_clk = ~i_sys_clk;
	end

	always @(posedge i_sys_clk)
	begin
		if (o_engine_done === 1'b1)
			done_cnt <= done_cnt + 1;
		if (o_regf_abort === 1'b1)
			abort_cnt <= abort_cnt + 1;
	end

	task automatic end_in_failure();
		$display("Test FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string msg);
		$display("Mismatch at time %0t: %s", $time, msg);
		end_in_failure();
	endtask

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			val  = {val[6:0], lfsr[0]};
		end
	endtask

	// script digit is {data byte, last word, rx error, rx preamble}
	function automatic logic [3:0] hex_digit(input byte c);
		return (c >= "A") ? 4'(c - "A" + 10) : 4'(c - "0");
	endfunction

	// answer one field with a done pulse 1 to 4 cycles after its enable
	task automatic serve_field(input logic [3:0] f);
		int         wait_cnt;
		logic [7:0] dly;
		wait_cnt = 0;
		while (o_tx_en !== 1'b1 && o_rx_en !== 1'b1)
		begin
			if (wait_cnt == WAIT_LIMIT)
			begin
				$display("Timeout at time %0t: engine raised no tx or rx enable", $time);
				end_in_failure();
			end
			@(negedge i_sys_clk);
			wait_cnt++;
		end
		i_engine_en = 1'b0; // start level already taken in idle
		if (mode_q.size() != 0)
		begin
			exp_mode = mode_q.pop_front();
			mode_chk = 1'b1;
		end
		take_bits(2, dly);
		repeat (1 + dly) @(negedge i_sys_clk);
		i_tx_mode_done = (o_tx_en === 1'b1);
		i_rx_mode_done = (o_rx_en === 1'b1);
		i_rx_pre       = f[0];
		i_rx_error     = f[1];
		i_frmcnt_last  = f[2];
		byte_done      = f[3];
		@(negedge i_sys_clk);
		i_tx_mode_done = 1'b0;
		i_rx_mode_done = 1'b0;
		i_rx_pre       = 1'b0;
		i_rx_error     = 1'b0;
		i_frmcnt_last  = 1'b0;
		byte_done      = 1'b0;
		mode_chk       = 1'b0;
		byte_idx       = byte_idx + f[3];
	endtask

	task automatic run_frame(input logic rd, input logic toc, input logic short_rd,
		input string script, input err_code_e err, input int n_done, input int n_abort);
		logic [7:0] idx;
		take_bits(5, idx);
		i_regf_dev_index  = dev_index_t'(idx);
		i_regf_wr_rd_bit  = rd;
		i_regf_toc        = toc;
		i_regf_short_read = short_rd;
		exp_special = {3'b000, idx[4:0]} + 8'd8; // dynamic address is index plus 8
		exp_base    = rd ? 12'd10 : 12'd1;
		exp_stall   = toc ? 5'd16 : 5'd10;
		exp_pattern = toc ? EXIT_PATTERN : RESTART_PATTERN;
		exp_err     = err;
		exp_done    = n_done;
		exp_abort   = n_abort;
		done_mark   = done_cnt;
		abort_mark  = abort_cnt;
		byte_idx    = 0;
		i_engine_en = 1'b1;
		for (int k = 0; k < script.len(); k++)
			if (script[k] != " ")
				serve_field(hex_digit(script[k]));
		frame_end = 1'b1;
		@(negedge i_sys_clk);
		frame_end = 1'b0;
		@(negedge i_sys_clk);
	endtask

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		mode_chk |-> o_tx_en && o_tx_mode == exp_mode)
	else
		report_mismatch("tx mode of a command field");

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_tx_en && o_tx_mode == SER_ADDRESS |-> o_tx_special_data == exp_special)
	else
		report_mismatch("target address on special data");

	// register file side and phy mode of each data byte
	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		byte_done |-> o_regf_addr == regf_addr_t'(exp_base + byte_idx)
		&& (i_regf_wr_rd_bit ? (o_regf_wr_en && o_rx_en && o_rx_mode == DESER_BYTE)
			: (o_regf_rd_en && o_tx_en && o_tx_mode == SER_BYTE)))
	else
		report_mismatch("register file address, strobe or mode of a data byte");

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_sclstall_en |-> o_sclstall_no_of_cycles == exp_stall && o_tx_mode == exp_pattern)
	else
		report_mismatch("stall count or tail pattern");

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		frame_end |-> o_regf_error_type == exp_err)
	else
		report_mismatch("error code at end of frame");

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		frame_end |-> done_cnt - done_mark == exp_done && abort_cnt - abort_mark == exp_abort)
	else
		report_mismatch("engine done or abort pulse count");

	assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		frame_end |-> !o_tx_en && !o_rx_en && !o_sclstall_en)
	else
		report_mismatch("engine not back in idle after the frame");

	initial
	begin
		i_sys_rst         = 1'b0;
		i_engine_en       = 1'b0;
		i_regf_toc        = 1'b0;
		i_regf_dev_index  = '0;
		i_regf_short_read = 1'b0;
		i_regf_wr_rd_bit  = 1'b0;
		i_tx_mode_done    = 1'b0;
		i_rx_mode_done    = 1'b0;
		i_rx_pre          = 1'b0;
		i_rx_error        = 1'b0;
		i_frmcnt_last     = 1'b0;
		lfsr      = 8'd80;
		mode_chk  = 1'b0;
		byte_done = 1'b0;
		frame_end = 1'b0;
		repeat (3) @(negedge i_sys_clk);
		i_sys_rst = 1'b1;
		@(negedge i_sys_clk);
		// write of two words, exit
		mode_q = '{SPECIAL_PRE, ZERO_PRE, SEVEN_ZEROS_TX, SER_ADDRESS, CALC_PARITY};
		run_frame(1'b0, 1'b1, 1'b0, "00000 00 880 01 884 0000 0", SUCCESS, 1, 0);
		// read of three bytes with pad, restart
		run_frame(1'b1, 1'b0, 1'b0, "00000 10 880 10 C00 4100 0", SUCCESS, 0, 0);
		run_frame(1'b0, 1'b0, 1'b0, "00000 0 1 0 0", NACK_ERR, 0, 0);          // nack
		run_frame(1'b1, 1'b1, 1'b0, "00000 10 88 2 0 0", PARITY_ERR, 1, 0);    // bad data parity
		run_frame(1'b1, 1'b0, 1'b0, "00000 10 88 0 4 1 0 2 0 0", CRC_ERR, 0, 0);
		run_frame(1'b1, 1'b1, 1'b1, "00000 10 88 0 0 0 0", SHORT_READ_ERR, 1, 0);
		run_frame(1'b1, 1'b1, 1'b0, "00000 10 88 0 0 1 0 0 0", SUCCESS, 1, 0); // early end allowed
		run_frame(1'b0, 1'b1, 1'b0, "00000 00 88 0 0 0 0 0", BUS_ABORT_ERR, 1, 1);
		if (ddr_engine_i.props_i.fail_cnt != 0)
		begin
			$display("protocol assertions in ddr_engine_props failed");
			end_in_failure();
		end
		else
		begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
rtl/ddr_pkg.sv
rtl/ddr_frame_fsm.sv
rtl/ddr_phy_ctrl.sv
rtl/ddr_regf_addr_gen.sv
rtl/ddr_engine.sv
dv/ddr_engine_props.sv
dv/ddr_engine_tb.sv
